// File: build.f
hdl/uvc_pkg.sv
hdl/uvc_payload_packer.sv
hdl/uvc_packet_fifo.sv
hdl/uvc_iso_streamer.sv
hdl/uvc_probe_responder.sv
hdl/uvc_stream_top.sv
testbench/tb_clock_gen.sv
testbench/uvc_stream_sva.sv
testbench/tb_uvc_stream.sv

// File: testbench/tb_uvc_stream.sv
/* testbench for the UVC stream top with a counter pixel source, paced sof, random endpoint 81
   back-pressure and probe reads, checked by the bound stream checker */
`timescale 1ns/10ps

module tb_uvc_stream;

    localparam int FRAME_W     = 4;
    localparam int FRAME_H     = 2;
    localparam int PACKET_SIZE = 8;
    localparam int FIFO_DEPTH  = 16;
    localparam int FRAMES      = 3;
    localparam int SOF_PERIOD  = 40;                    // cycles per USB frame
    localparam int FRAME_BYTES = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);
    localparam int PKTS        = (FRAME_BYTES + PACKET_SIZE - 3) / (PACKET_SIZE - 2);
    localparam int EP_BYTES    = FRAMES * (FRAME_BYTES + 2 * PKTS);    // headers included
    // one packet per sof plus a spare period for the probe reads with a 5x margin
    localparam int CYCLE_LIMIT = 5 * (FRAMES * PKTS + 1) * SOF_PERIOD;

    logic        clk, usb_rstn, sof, vf_sof, vf_req, ep81_ready, ep81_valid;
    logic [7:0]  vf_byte, ep81_data, ep00_resp;
    logic [63:0] ep00_setup_cmd;
    logic [8:0]  ep00_resp_idx;
    int          cyc_cnt = 0;                           // timeout counter
    int          pix_cnt = 0;                           // next pixel source value
    int          acc_bytes = 0;                         // bytes taken on endpoint 81
    int          chk_errors;

    tb_clock_gen i_tb_clock_gen (
        .clk      (clk),
        .usb_rstn (usb_rstn)
    );

    uvc_stream_top #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .PACKET_SIZE (PACKET_SIZE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_uvc_stream_top (.*);

    assign chk_errors = i_uvc_stream_top.i_uvc_stream_sva.err_cnt;

    always @(chk_errors) begin
        if (chk_errors != 0) begin
            $display("Simulation failed");
            $fatal(1, "stream checker assertion failed");
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // pixel source answers a request in the next cycle and the host is ready about 70% of cycles
    task automatic drive_stream(input logic req_seen, input logic sof_seen, input logic sof_now);
        if (sof_seen) begin
            pix_cnt = 0;                                // new video frame
        end
        if (req_seen) begin
            vf_byte = 8'(pix_cnt);
            pix_cnt++;
        end
        sof        = sof_now;
        ep81_ready = ($urandom % 10) < 7;
    endtask

    initial begin
        logic        req_seen;
        logic        sof_seen;
        int          cyc;
        sof            = 1'b0;
        vf_byte        = 8'h00;
        ep81_ready     = 1'b0;
        ep00_setup_cmd = 64'h0;
        ep00_resp_idx  = 9'd0;
        void'($urandom(32'h6f4f));
        cyc            = 0;
        @(posedge usb_rstn);
        while (acc_bytes < EP_BYTES) begin
            @(negedge clk);
            req_seen = vf_req;                          // settled mid cycle
            sof_seen = vf_sof;
            if (ep81_valid && ep81_ready) begin
                acc_bytes++;
            end
            @(posedge clk);
            #1;
            cyc++;
            drive_stream(req_seen, sof_seen, (cyc % SOF_PERIOD) == 0);
        end
        sof        = 1'b0;
        ep81_ready = 1'b0;
        // GET_CUR on the probe control with wLength 34
        ep00_setup_cmd = {16'd34, 32'h0001_0100, 8'h81, 8'hA1};
        for (int i = 0; i < 34; i++) begin
            ep00_resp_idx = 9'(i);
            @(posedge clk);
            #1;
        end
        ep00_setup_cmd[7:0] = 8'h21;                    // host to device request reads as zero
        ep00_resp_idx       = 9'd18;
        repeat (3) @(posedge clk);
        if (chk_errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "stream checker reported errors");
        end
    end

endmodule

// File: testbench/uvc_stream_sva.sv
/* concurrent checks bound into the UVC stream top
   header and payload bytes follow position counters and probe bytes follow the index */
`timescale 1ns/10ps

module uvc_stream_sva #(
    parameter int FRAME_W     = 320,
    parameter int FRAME_H     = 240,
    parameter int PACKET_SIZE = 802
) (
    input logic        clk, usb_rstn, sof, vf_sof, vf_req,
    input logic        ep81_valid, ep81_ready,
    input logic [7:0]  ep81_data, ep00_resp,
    input logic [63:0] ep00_setup_cmd,
    input logic [8:0]  ep00_resp_idx
);

    localparam int FRAME_BYTES = FRAME_W * FRAME_H * 2;    // two YUY2 bytes per pixel
    localparam int PAYLOAD     = PACKET_SIZE - 2;          // room left after the header
    localparam int NPKT        = (FRAME_BYTES + PAYLOAD - 1) / PAYLOAD;
    localparam int LAST_LEN    = FRAME_BYTES - (NPKT - 1) * PAYLOAD + 2;

    int         err_cnt = 0;                               // failed checks so far
    int         pos, pkt, pix;                             // byte in packet, packet and pixel in frame
    int         pkt_len;
    logic       fid_ref, fid_seen, seen_sof;
    logic       accept, last_pkt, fid_exp, probe_rd, fsize_idx, resp_chk;
    logic [7:0] exp_byte, exp_resp;

    assign accept    = ep81_valid & ep81_ready;
    assign last_pkt  = (pkt == NPKT - 1);
    assign pkt_len   = last_pkt ? LAST_LEN : PACKET_SIZE;
    assign fid_exp   = (pkt == 0) ? ~fid_ref : fid_ref;    // flips at each new frame
    assign exp_byte  = (pos == 0) ? 8'd2
                     : (pos == 1) ? {6'b100000, last_pkt, fid_seen ? fid_exp : ep81_data[0]}
                     : 8'(pix);
    assign probe_rd  = (ep00_setup_cmd[7:0] == 8'hA1)
                    && (ep00_setup_cmd[47:16] == 32'h0001_0100)
                    && (ep00_resp_idx < 9'd34);
    assign fsize_idx = (ep00_resp_idx >= 9'd18) && (ep00_resp_idx <= 9'd21);
    assign resp_chk  = !probe_rd || (ep00_resp_idx == 9'd2) || fsize_idx;
    assign exp_resp  = !probe_rd ? 8'h00
                     : (ep00_resp_idx == 9'd2) ? 8'h01     // bFormatIndex
                     : 8'(FRAME_BYTES >> (8 * (ep00_resp_idx - 9'd18)));

    task automatic report_failure(input string msg);
        err_cnt++;
        $error("ERR %0t: %s", $time, msg);
    endtask

    // --------------------------------------------------------------------------
    // position model of the bytes leaving endpoint 81
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            pos      <= 0;
            pkt      <= 0;
            pix      <= 0;
            fid_ref  <= 1'b0;
            fid_seen <= 1'b0;
            seen_sof <= 1'b0;
        end else begin
            seen_sof <= seen_sof | sof;
            if (accept) begin
                pos <= (pos == pkt_len - 1) ? 0 : pos + 1;
                pix <= (pos == pkt_len - 1 && last_pkt) ? 0    // frame done
                     : (pos >= 2) ? pix + 1 : pix;
                if (pos == 1) begin
                    fid_ref  <= ep81_data[0];
                    fid_seen <= 1'b1;
                end
                if (pos == pkt_len - 1) begin
                    pkt <= last_pkt ? 0 : pkt + 1;
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk) !usb_rstn || $rose(usb_rstn)
        |-> !vf_sof && !vf_req && !ep81_valid)
        else report_failure("stream outputs active during or at release of reset");
    a_wait_sof: assert property (@(posedge clk) disable iff (!usb_rstn)
        !seen_sof |-> !ep81_valid)
        else report_failure("ep81_valid raised before the first sof");
    a_stall_hold: assert property (@(posedge clk) disable iff (!usb_rstn)
        ep81_valid && !ep81_ready |=> ep81_valid && $stable(ep81_data))
        else report_failure("endpoint 81 byte dropped or changed while stalled");
    a_stream_byte: assert property (@(posedge clk) disable iff (!usb_rstn)
        accept |-> ep81_data == exp_byte)
        else report_failure($sformatf("byte %0d of packet %0d is %h, expected %h",
                                      $sampled(pos), $sampled(pkt), $sampled(ep81_data),
                                      $sampled(exp_byte)));
    a_packet_end: assert property (@(posedge clk) disable iff (!usb_rstn)
        accept && pos == pkt_len - 1 |=> !ep81_valid)
        else report_failure("ep81_valid still high after the last byte of a packet");
    a_probe_resp: assert property (@(posedge clk) disable iff (!usb_rstn)
        resp_chk |=> ep00_resp == $past(exp_resp))
        else report_failure($sformatf("probe response byte %h is wrong",
                                      $sampled(ep00_resp)));

endmodule

bind uvc_stream_top uvc_stream_sva #(
    .FRAME_W (FRAME_W), .FRAME_H (FRAME_H), .PACKET_SIZE (PACKET_SIZE)
) i_uvc_stream_sva (.*);

// File: testbench/tb_clock_gen.sv
/* free-running clock and active-low reset for the UVC stream testbench */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic usb_rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        usb_rstn = 1'b0;                                // reset from time zero
        repeat (RST_CYCLES) @(posedge clk);
        #1 usb_rstn = 1'b1;                             // released just after an edge
    end

endmodule

// File: hdl/uvc_stream_top.sv
/* video side of a full-speed UVC camera built from packer, packet FIFO, iso streamer and
   probe responder, with the USB core boundary as plain ports */
`timescale 1ns/10ps

module uvc_stream_top #(
    parameter int FRAME_W     = 320,                    // must be even
    parameter int FRAME_H     = 240,                    // must be even
    parameter int PACKET_SIZE = 802,                    // endpoint 81 max packet incl header
    parameter int FIFO_DEPTH  = 16                      // power of two
) (
    input  logic           clk,
    input  logic           usb_rstn,
    input  logic           sof,                         // start of USB frame from the core
    output logic           vf_sof,
    output logic           vf_req,
    input  uvc_pkg::byte_t vf_byte,
    input  logic           ep81_ready,
    output uvc_pkg::byte_t ep81_data,
    output logic           ep81_valid,
    input  logic [63:0]    ep00_setup_cmd,
    input  logic [8:0]     ep00_resp_idx,
    output uvc_pkg::byte_t ep00_resp
);

    localparam int FRAME_BYTES = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);

    // YUY2 pairs pixels, so odd sizes are rejected at elaboration
    if ((FRAME_W % 2 != 0) || (FRAME_H % 2 != 0) || (FRAME_BYTES == 0)) begin : g_size_check
        $error("frame width and height must be even and nonzero");
    end

    // ------------------------------------------------------------------------
    // packer -> FIFO -> streamer
    // ------------------------------------------------------------------------
    uvc_pkg::byte_t wr_data;
    uvc_pkg::byte_t rd_data;
    logic           wr_en;
    logic           wr_last;
    logic           full;
    logic           rd_en;
    logic           rd_last;
    logic           empty;

    uvc_payload_packer #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .PACKET_SIZE (PACKET_SIZE)
    ) i_uvc_payload_packer (
        .clk      (clk),      .usb_rstn (usb_rstn), .full    (full),
        .vf_byte  (vf_byte),  .vf_sof   (vf_sof),   .vf_req  (vf_req),
        .wr_en    (wr_en),    .wr_last  (wr_last),  .wr_data (wr_data)
    );

    uvc_packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_uvc_packet_fifo (
        .clk     (clk),     .usb_rstn (usb_rstn), .wr_en   (wr_en),
        .wr_last (wr_last), .rd_en    (rd_en),    .wr_data (wr_data),
        .rd_data (rd_data), .rd_last  (rd_last),  .full    (full),
        .empty   (empty)
    );

    uvc_iso_streamer i_uvc_iso_streamer (
        .clk        (clk),        .usb_rstn   (usb_rstn),   .sof       (sof),
        .empty      (empty),      .rd_last    (rd_last),    .ep81_ready(ep81_ready),
        .rd_data    (rd_data),    .rd_en      (rd_en),      .ep81_valid(ep81_valid),
        .ep81_data  (ep81_data)
    );

    // control endpoint side, independent of the stream path
    uvc_probe_responder #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .PACKET_SIZE (PACKET_SIZE)
    ) i_uvc_probe_responder (
        .clk            (clk),
        .usb_rstn       (usb_rstn),
        .ep00_setup_cmd (ep00_setup_cmd),
        .ep00_resp_idx  (ep00_resp_idx),
        .ep00_resp      (ep00_resp)
    );

endmodule

// File: hdl/uvc_probe_responder.sv
/* answers UVC video probe/commit GET requests on the control endpoint
   with the 34-byte parameter block, one registered byte per response index */
`timescale 1ns/10ps

module uvc_probe_responder #(
    parameter int FRAME_W     = 320,
    parameter int FRAME_H     = 240,
    parameter int PACKET_SIZE = 802
) (
    input  logic           clk,
    input  logic           usb_rstn,
    input  logic [63:0]    ep00_setup_cmd,              // raw 8-byte setup packet
    input  logic [8:0]     ep00_resp_idx,               // byte index into the response
    output uvc_pkg::byte_t ep00_resp
);

    localparam int          FRAME_BYTES  = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);
    localparam int          PAYLOAD_SIZE = PACKET_SIZE - uvc_pkg::HEADER_LEN;
    localparam int          PKT_COUNT    = (FRAME_BYTES + PAYLOAD_SIZE - 1) / PAYLOAD_SIZE;
    localparam logic [31:0] INTERVAL     = 32'(PKT_COUNT * 10000);   // 1 packet per ms, 100 ns units
    localparam logic [31:0] MAX_FRAME    = 32'(FRAME_BYTES);
    localparam logic [31:0] MAX_PAYLOAD  = 32'(PACKET_SIZE);
    localparam logic [31:0] CLK_FREQ     = uvc_pkg::CLOCK_FREQ_HZ;

    // ------------------------------------------------------------------------
    // probe / commit block, little endian fields
    // ------------------------------------------------------------------------
    localparam uvc_pkg::byte_t PROBE_BLOCK [uvc_pkg::PROBE_LEN] = '{
        8'h00, 8'h00,                                           // bmHint
        8'h01,                                                  // bFormatIndex
        8'h01,                                                  // bFrameIndex
        INTERVAL[7:0], INTERVAL[15:8], INTERVAL[23:16], INTERVAL[31:24],
        8'h00, 8'h00,                                           // wKeyFrameRate
        8'h00, 8'h00,                                           // wPFrameRate
        8'h00, 8'h00,                                           // wCompQuality
        8'h00, 8'h00,                                           // wCompWindowSize
        8'h01, 8'h00,                                           // wDelay, ms
        MAX_FRAME[7:0], MAX_FRAME[15:8], MAX_FRAME[23:16], MAX_FRAME[31:24],
        MAX_PAYLOAD[7:0], MAX_PAYLOAD[15:8], MAX_PAYLOAD[23:16], MAX_PAYLOAD[31:24],
        CLK_FREQ[7:0], CLK_FREQ[15:8], CLK_FREQ[23:16], CLK_FREQ[31:24],
        8'h03,                                                  // bmFramingInfo, fid + eof
        8'h00, 8'h00, 8'h00                                     // version fields
    };

    logic match;                                        // probe/commit read in range

    assign match = (ep00_setup_cmd[7:0] == uvc_pkg::PROBE_REQ_TYPE)
                && (ep00_setup_cmd[47:16] == uvc_pkg::PROBE_SELECTOR)
                && (ep00_resp_idx < 9'(uvc_pkg::PROBE_LEN));

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            ep00_resp <= '0;
        end else if (match) begin
            ep00_resp <= PROBE_BLOCK[ep00_resp_idx[5:0]];
        end else begin
            ep00_resp <= '0;                            // other requests read as zero
        end
    end

endmodule

// File: hdl/uvc_iso_streamer.sv
/* releases one packet per USB start-of-frame from the packet FIFO onto endpoint 81
   using the valid/ready level pair of the USB core */
`timescale 1ns/10ps

module uvc_iso_streamer (
    input  logic           clk,
    input  logic           usb_rstn,
    input  logic           sof,                         // start of USB frame, 1 ms
    input  logic           empty,
    input  logic           rd_last,                     // head byte ends a packet
    input  logic           ep81_ready,
    input  uvc_pkg::byte_t rd_data,
    output logic           rd_en,
    output logic           ep81_valid,
    output uvc_pkg::byte_t ep81_data
);

    logic in_pkt;                                       // a packet slot is open
    logic accept;                                       // byte taken by the host

    // ------------------------------------------------------------------------
    // endpoint side
    // ------------------------------------------------------------------------
    assign ep81_valid = in_pkt & ~empty;                // drops if FIFO runs dry mid packet
    assign ep81_data  = rd_data;                        // head stays put until popped
    assign accept     = ep81_valid & ep81_ready;
    assign rd_en      = accept;

    // sof opens a slot, last byte closes it, sof during a packet is ignored
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            in_pkt <= 1'b0;
        end else if (!in_pkt) begin
            in_pkt <= sof;
        end else if (accept && rd_last) begin
            in_pkt <= 1'b0;                             // wait for the next sof
        end
    end

endmodule

// File: hdl/uvc_packet_fifo.sv
/* byte FIFO between packer and iso streamer, each entry carries a last-of-packet flag
   head entry is visible on rd_data while empty is low, rd_en pops it */
`timescale 1ns/10ps

module uvc_packet_fifo #(
    parameter int FIFO_DEPTH = 16                       // power of two
) (
    input  logic           clk,
    input  logic           usb_rstn,
    input  logic           wr_en,
    input  logic           wr_last,
    input  logic           rd_en,
    input  uvc_pkg::byte_t wr_data,
    output uvc_pkg::byte_t rd_data,
    output logic           rd_last,
    output logic           full,
    output logic           empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    uvc_pkg::byte_t mem_data [FIFO_DEPTH];
    logic           mem_last [FIFO_DEPTH];
    logic [AW:0]    wr_ptr;                             // extra msb tells full from empty
    logic [AW:0]    rd_ptr;
    logic           do_wr;
    logic           do_rd;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty   = (wr_ptr == rd_ptr);
    assign do_wr   = wr_en & ~full;                     // overflow writes dropped
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem_data[rd_ptr[AW-1:0]];          // show-ahead
    assign rd_last = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr[AW-1:0]] <= wr_data;
            mem_last[wr_ptr[AW-1:0]] <= wr_last;
        end
    end

endmodule

// File: hdl/uvc_payload_packer.sv
/* builds UVC isochronous packets (2-byte header + YUY2 payload) and fetches pixels
   from the pixel source, writing one byte per cycle into the packet FIFO while not full */
`timescale 1ns/10ps

module uvc_payload_packer #(
    parameter int FRAME_W     = 320,                    // pixels, even
    parameter int FRAME_H     = 240,                    // lines, even
    parameter int PACKET_SIZE = 802                     // bytes incl header
) (
    input  logic           clk,
    input  logic           usb_rstn,
    input  logic           full,                        // FIFO cannot take a byte
    input  uvc_pkg::byte_t vf_byte,                     // pixel byte, cycle after vf_req
    output logic           vf_sof,                      // first byte of a video frame written
    output logic           vf_req,                      // ask source for the next pixel byte
    output logic           wr_en,
    output logic           wr_last,                     // last byte of a packet
    output uvc_pkg::byte_t wr_data
);

    // ------------------------------------------------------------------------
    // frame geometry
    // ------------------------------------------------------------------------
    localparam int FRAME_BYTES  = uvc_pkg::frame_bytes(FRAME_W, FRAME_H);
    localparam int PAYLOAD_SIZE = PACKET_SIZE - uvc_pkg::HEADER_LEN;
    localparam int PKT_COUNT    = (FRAME_BYTES + PAYLOAD_SIZE - 1) / PAYLOAD_SIZE;
    localparam int LAST_PAYLOAD = (FRAME_BYTES % PAYLOAD_SIZE == 0) ? PAYLOAD_SIZE
                                                                    : FRAME_BYTES % PAYLOAD_SIZE;
    localparam int LAST_SIZE    = LAST_PAYLOAD + uvc_pkg::HEADER_LEN;
    localparam int BW           = $clog2(PACKET_SIZE + 1);  // byte counter width
    localparam int PW           = (PKT_COUNT > 1) ? $clog2(PKT_COUNT) : 1;

    uvc_pkg::packer_state_e state;
    logic [BW-1:0]  bcnt;                               // byte index within packet
    logic [PW-1:0]  pcnt;                               // packet index within frame
    logic           fid;                                // frame id, toggles per frame
    logic           plast;                              // current packet ends the frame
    logic [BW-1:0]  psize;                              // size of current packet
    logic           issue;                              // a new byte slot starts this cycle
    logic           pend;                               // slot waiting to be written
    logic           pend_pix;                           // slot carries a pixel byte
    logic           pend_sof;                           // slot is byte 0 of packet 0
    logic           held;                               // pixel already captured in hold_data
    uvc_pkg::byte_t hold_data;                          // header byte or stalled pixel

    assign plast   = (pcnt == PW'(PKT_COUNT - 1));
    assign psize   = plast ? BW'(LAST_SIZE) : BW'(PACKET_SIZE);
    assign issue   = ~full;                             // pending slot drains in the same cycle
    assign vf_req  = issue & (state == uvc_pkg::ST_PAYLOAD);
    assign wr_en   = pend & ~full;
    assign wr_data = (pend_pix & ~held) ? vf_byte : hold_data;
    assign vf_sof  = wr_en & pend_sof;

    // ------------------------------------------------------------------------
    // sequencing and slot control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state    <= uvc_pkg::ST_HDR_LEN;
            bcnt     <= '0;
            pcnt     <= '0;
            fid      <= 1'b0;
            pend     <= 1'b0;
            pend_pix <= 1'b0;
            pend_sof <= 1'b0;
            held     <= 1'b0;
            wr_last  <= 1'b0;
        end else if (issue) begin
            pend     <= 1'b1;
            held     <= 1'b0;
            pend_pix <= (state == uvc_pkg::ST_PAYLOAD);
            pend_sof <= (state == uvc_pkg::ST_HDR_LEN) && (pcnt == '0);
            wr_last  <= (state == uvc_pkg::ST_PAYLOAD) && (bcnt + 1'b1 == psize);
            bcnt     <= bcnt + 1'b1;
            case (state)
                uvc_pkg::ST_HDR_LEN: state <= uvc_pkg::ST_HDR_BFH;
                uvc_pkg::ST_HDR_BFH: state <= uvc_pkg::ST_PAYLOAD;
                default: begin
                    if (bcnt + 1'b1 == psize) begin     // packet done, next header
                        bcnt  <= '0;
                        state <= uvc_pkg::ST_HDR_LEN;
                        if (plast) begin
                            pcnt <= '0;
                            fid  <= ~fid;               // new video frame
                        end else begin
                            pcnt <= pcnt + 1'b1;
                        end
                    end
                end
            endcase
        end else if (pend & pend_pix & ~held) begin
            held <= 1'b1;                               // FIFO full, pixel kept in hold_data
        end
    end

    // header bytes are loaded at issue, stalled pixels caught one cycle later
    always_ff @(posedge clk) begin
        if (issue) begin
            if (state == uvc_pkg::ST_HDR_LEN) begin
                hold_data <= uvc_pkg::HEADER_LEN;
            end else if (state == uvc_pkg::ST_HDR_BFH) begin
                hold_data <= {uvc_pkg::BFH_BASE, plast, fid};   // eof only on last packet
            end
        end else if (pend & pend_pix & ~held) begin
            hold_data <= vf_byte;
        end
    end

endmodule

// File: hdl/uvc_pkg.sv
/* shared constants, state enum and frame-size helper for the UVC video stream path
   modules reach these by scoped names */

package uvc_pkg;

    typedef logic [7:0] byte_t;                         // one data byte on every byte path

    // ------------------------------------------------------------------------
    // payload header
    // ------------------------------------------------------------------------
    localparam byte_t       HEADER_LEN = 8'd2;          // HLE byte value and header byte count
    localparam logic [5:0]  BFH_BASE   = 6'b100000;     // EOH set and no PTS/SCR/still/error bits

    // ------------------------------------------------------------------------
    // probe / commit control
    // ------------------------------------------------------------------------
    localparam byte_t       PROBE_REQ_TYPE = 8'hA1;     // device to host class request to an interface
    localparam logic [31:0] PROBE_SELECTOR = 32'h0001_0100; // wValue and wIndex of setup packet
    localparam int          PROBE_LEN      = 34;        // UVC 1.1 probe/commit block size
    localparam logic [31:0] CLOCK_FREQ_HZ  = 32'd6_000_000; // reported in dwClockFrequency

    // packer sequence within one packet
    typedef enum logic [1:0] {
        ST_HDR_LEN,                                     // header length byte
        ST_HDR_BFH,                                     // BFH with eof and fid
        ST_PAYLOAD                                      // pixel bytes from the source
    } packer_state_e;

    // YUY2 carries two bytes per pixel
    function automatic logic [31:0] frame_bytes(input int width, input int height);
        return 32'(width * height * 2);
    endfunction

endpackage
